// ==== hdl/fetch_pkg.sv ====
// Instruction prefetch path shared constants and payload types
package fetch_pkg;

  // Instruction address width
  localparam int ADDR_W = 32;

  // Instruction word width
  localparam int DATA_W = 32;

  // Entries per FIFO, also the limit on requests in flight plus buffered
  localparam int FIFO_DEPTH = 4;

  // Occupancy and discard counters must be able to hold FIFO_DEPTH
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Payload of the address FIFO
  typedef logic [ADDR_W-1:0] fetch_addr_t;

  // Returned instruction paired with the address it was fetched from
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    fetch_addr_t       addr;
  } fetch_entry_t;

endpackage

// ==== hdl/fetch_fifo.sv ====
// Synchronous FIFO with a type-parameterised payload, flush and occupancy count
`timescale 1ns/10ps

module fetch_fifo #(
  parameter type payload_t = fetch_pkg::fetch_addr_t,
  parameter int  DEPTH     = fetch_pkg::FIFO_DEPTH
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flush_i,
  input  logic                        push_i,
  input  payload_t                    push_data_i,
  input  logic                        pop_i,
  output payload_t                    pop_data_o,
  output logic                        empty_o,
  output logic                        full_o,
  output logic [fetch_pkg::CNT_W-1:0] count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t                    mem_q [DEPTH];
  logic [PTR_W-1:0]            wptr_q;
  logic [PTR_W-1:0]            rptr_q;
  logic [fetch_pkg::CNT_W-1:0] count_q;
  logic                        do_push;
  logic                        do_pop;

  // A flush wins over any push or pop in the same cycle
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i;

  assign pop_data_o = mem_q[rptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == DEPTH);
  assign count_o    = count_q;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Upstream credit accounting must keep the FIFO from overflowing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    do_push |-> !full_o);

  // Every pop has to match an earlier push
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    do_pop |-> !empty_o);

endmodule

// ==== hdl/fetch_prefetch_controller.sv ====
// Prefetch controller that issues instruction requests and pairs responses with addresses
`timescale 1ns/10ps

module fetch_prefetch_controller (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          fetch_enable_i,
  input  logic                          branch_i,
  input  fetch_pkg::fetch_addr_t        branch_addr_i,

  // Instruction memory bus
  output logic                          instr_req_o,
  output fetch_pkg::fetch_addr_t        instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::DATA_W-1:0]  instr_rdata_i,

  // Address FIFO
  output logic                          addr_push_o,
  output fetch_pkg::fetch_addr_t        addr_push_data_o,
  output logic                          addr_pop_o,
  input  fetch_pkg::fetch_addr_t        addr_head_i,
  input  logic [fetch_pkg::CNT_W-1:0]   addr_count_i,

  // Instruction FIFO and downstream occupancy
  output logic                          entry_push_o,
  output fetch_pkg::fetch_entry_t       entry_push_data_o,
  input  logic [fetch_pkg::CNT_W-1:0]   buffered_count_i
);

  logic                          req_q;
  fetch_pkg::fetch_addr_t        addr_q;
  logic                          branch_pend_q;
  fetch_pkg::fetch_addr_t        branch_tgt_q;
  logic [fetch_pkg::CNT_W-1:0]   discard_cnt_q;
  logic                          req_hold;
  logic                          discard;
  logic [fetch_pkg::CNT_W:0]     buffered_eff;
  logic [fetch_pkg::CNT_W:0]     credit_sum;
  logic                          credit_ok;

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  // Request is waiting for its grant and must not change
  assign req_hold = req_q && !instr_gnt_i;

  // Occupancy as seen next cycle; a branch empties the buffers behind the address FIFO
  assign buffered_eff = branch_i ? '0 : {1'b0, buffered_count_i};
  assign credit_sum   = {1'b0, addr_count_i} + buffered_eff +
                        {{fetch_pkg::CNT_W{1'b0}}, instr_gnt_i};
  assign credit_ok    = (credit_sum < fetch_pkg::FIFO_DEPTH);

  // Address FIFO tracks every granted request in order
  assign addr_push_o      = req_q && instr_gnt_i;
  assign addr_push_data_o = addr_q;
  assign addr_pop_o       = instr_rvalid_i;

  // Responses to requests older than the last branch are dropped
  assign discard           = branch_i || (discard_cnt_q != '0);
  assign entry_push_o      = instr_rvalid_i && !discard;
  assign entry_push_data_o = '{rdata: instr_rdata_i, addr: addr_head_i};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q         <= 1'b0;
      addr_q        <= '0;
      branch_pend_q <= 1'b0;
    end else if (req_hold) begin
      // Redirect is deferred until the pending request is granted
      if (branch_i) begin
        branch_pend_q <= 1'b1;
      end
    end else begin
      req_q         <= fetch_enable_i && credit_ok;
      branch_pend_q <= 1'b0;
      if (branch_i) begin
        addr_q <= branch_addr_i;
      end else if (instr_gnt_i) begin
        addr_q <= branch_pend_q ? branch_tgt_q : addr_q + 'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hold && branch_i) begin
      branch_tgt_q <= branch_addr_i;
    end
  end

  // Discard counter covers requests granted up to the branch plus a deferred one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      discard_cnt_q <= '0;
    end else if (branch_i) begin
      discard_cnt_q <= addr_count_i + instr_gnt_i - instr_rvalid_i;
    end else begin
      discard_cnt_q <= discard_cnt_q + (instr_gnt_i && branch_pend_q) -
                       (instr_rvalid_i && (discard_cnt_q != '0));
    end
  end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // Stale responses can only belong to requests still tracked in the address FIFO
  a_discard_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    discard_cnt_q <= addr_count_i);

endmodule

// ==== hdl/fetch_output_stage.sv ====
// Output register slice that presents fetched instructions to decode
`timescale 1ns/10ps

module fetch_output_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,

  // Instruction FIFO head
  input  logic                          fifo_empty_i,
  input  fetch_pkg::fetch_entry_t       fifo_head_i,
  output logic                          fifo_pop_o,

  // Decode port
  output logic                          instr_valid_o,
  output logic [fetch_pkg::DATA_W-1:0]  instr_rdata_o,
  output fetch_pkg::fetch_addr_t        decode_addr_o,
  input  logic                          instr_ready_i,

  output logic                          occupied_o
);

  logic                    valid_q;
  fetch_pkg::fetch_entry_t entry_q;

  // Refill when empty or when decode takes the current entry
  assign fifo_pop_o = !fifo_empty_i && !flush_i && (!valid_q || instr_ready_i);

  assign instr_valid_o = valid_q;
  assign instr_rdata_o = entry_q.rdata;
  assign decode_addr_o = entry_q.addr;
  assign occupied_o    = valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (fifo_pop_o) begin
      valid_q <= 1'b1;
    end else if (instr_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      entry_q <= fifo_head_i;
    end
  end

  // Decode back-pressure must not disturb the presented instruction
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_o && !instr_ready_i && !flush_i
    |=> instr_valid_o && $stable(instr_rdata_o) && $stable(decode_addr_o));

endmodule

// ==== hdl/fetch_unit.sv ====
// Instruction fetch unit joining prefetch control, address and instruction FIFOs and output stage
`timescale 1ns/10ps

module fetch_unit (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          fetch_enable_i,
  input  logic                          branch_i,
  input  fetch_pkg::fetch_addr_t        branch_addr_i,

  // Instruction memory bus
  output logic                          instr_req_o,
  output fetch_pkg::fetch_addr_t        instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::DATA_W-1:0]  instr_rdata_i,

  // Decode port
  output logic                          instr_valid_o,
  output logic [fetch_pkg::DATA_W-1:0]  instr_rdata_o,
  output fetch_pkg::fetch_addr_t        decode_addr_o,
  input  logic                          instr_ready_i
);

  logic                          addr_push;
  fetch_pkg::fetch_addr_t        addr_push_data;
  logic                          addr_pop;
  fetch_pkg::fetch_addr_t        addr_head;
  logic                          addr_empty;
  logic                          addr_full;
  logic [fetch_pkg::CNT_W-1:0]   addr_count;

  logic                          entry_push;
  fetch_pkg::fetch_entry_t       entry_push_data;
  logic                          entry_pop;
  fetch_pkg::fetch_entry_t       entry_head;
  logic                          entry_empty;
  logic                          entry_full;
  logic [fetch_pkg::CNT_W-1:0]   entry_count;

  logic                          out_occupied;
  logic [fetch_pkg::CNT_W-1:0]   buffered_count;

  // Instructions held past the memory bus, in the FIFO and the output register
  assign buffered_count = entry_count + out_occupied;

  fetch_prefetch_controller i_prefetch_controller (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .fetch_enable_i    (fetch_enable_i),
    .branch_i          (branch_i),
    .branch_addr_i     (branch_addr_i),
    .instr_req_o       (instr_req_o),
    .instr_addr_o      (instr_addr_o),
    .instr_gnt_i       (instr_gnt_i),
    .instr_rvalid_i    (instr_rvalid_i),
    .instr_rdata_i     (instr_rdata_i),
    .addr_push_o       (addr_push),
    .addr_push_data_o  (addr_push_data),
    .addr_pop_o        (addr_pop),
    .addr_head_i       (addr_head),
    .addr_count_i      (addr_count),
    .entry_push_o      (entry_push),
    .entry_push_data_o (entry_push_data),
    .buffered_count_i  (buffered_count)
  );

  // Outstanding addresses survive a branch so responses stay paired
  fetch_fifo #(
    .payload_t (fetch_pkg::fetch_addr_t),
    .DEPTH     (fetch_pkg::FIFO_DEPTH)
  ) i_addr_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (1'b0),
    .push_i      (addr_push),
    .push_data_i (addr_push_data),
    .pop_i       (addr_pop),
    .pop_data_o  (addr_head),
    .empty_o     (addr_empty),
    .full_o      (addr_full),
    .count_o     (addr_count)
  );

  fetch_fifo #(
    .payload_t (fetch_pkg::fetch_entry_t),
    .DEPTH     (fetch_pkg::FIFO_DEPTH)
  ) i_instr_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (branch_i),
    .push_i      (entry_push),
    .push_data_i (entry_push_data),
    .pop_i       (entry_pop),
    .pop_data_o  (entry_head),
    .empty_o     (entry_empty),
    .full_o      (entry_full),
    .count_o     (entry_count)
  );

  fetch_output_stage i_output_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (branch_i),
    .fifo_empty_i  (entry_empty),
    .fifo_head_i   (entry_head),
    .fifo_pop_o    (entry_pop),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .decode_addr_o (decode_addr_o),
    .instr_ready_i (instr_ready_i),
    .occupied_o    (out_occupied)
  );

  // A response always finds its address waiting in the address FIFO
  a_rvalid_has_addr: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_rvalid_i |-> !addr_empty);

  // Credit accounting keeps the instruction FIFO from filling while a response is accepted
  a_entry_room: assert property (@(posedge clk_i) disable iff (rst_i)
    entry_push |-> !entry_full);

  // No grant while the address FIFO has no free slot
  a_gnt_has_room: assert property (@(posedge clk_i) disable iff (rst_i)
    addr_push |-> !addr_full);

endmodule

// ==== verification/fetch_mem_model.sv ====
// Instruction memory model with random grant and return delays and in-order responses
`timescale 1ns/10ps

module fetch_mem_model (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  localparam int          MAX_GNT_DELAY = 2;
  localparam int          MIN_RSP_DELAY = 1;
  localparam int          MAX_RSP_DELAY = 3;
  localparam logic [31:0] CONTENT_XOR   = 32'hA5A5_0000;

  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q [$];
  int          cycle;
  int          gnt_wait;
  int          last_due;
  logic [31:0] gnt_addr;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    cycle    = 0;
    gnt_wait = 0;
    last_due = 0;
    gnt_addr = '0;
  end

  // Outputs change on the falling edge, the DUT samples them on the rising edge
  always @(negedge clk_i) begin
    int due;
    cycle = cycle + 1;
    if (rst_i) begin
      rsp_addr_q.delete();
      rsp_due_q.delete();
      gnt_wait = 0;
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      // The grant of the last cycle completed a handshake
      if (gnt_o) begin
        due = cycle - 1 + $urandom_range(MAX_RSP_DELAY, MIN_RSP_DELAY);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(gnt_addr);
        rsp_due_q.push_back(due);
      end
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_addr_q[0] ^ CONTENT_XOR;
        void'(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
      if (req_i && gnt_wait == 0) begin
        gnt_o    <= 1'b1;
        gnt_addr = addr_i;
        gnt_wait = $urandom_range(MAX_GNT_DELAY, 0);
      end else begin
        gnt_o <= 1'b0;
        if (req_i) begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

endmodule

// ==== verification/fetch_unit_tb.sv ====
// Testbench for the fetch unit with random memory delays, decode stalls and branches
`timescale 1ns/10ps

module fetch_unit_tb;

  localparam int          CLK_PERIOD      = 8;
  localparam int          RST_CYCLES      = 5;
  localparam int          RUN_CYCLES      = 400;
  localparam int          WATCHDOG_CYCLES = RST_CYCLES + RUN_CYCLES + RUN_CYCLES / 2;
  localparam int          MIN_ACCEPTED    = RUN_CYCLES / 8;
  localparam int          SEED            = 68;
  localparam logic [31:0] CONTENT_XOR     = 32'hA5A5_0000;

  logic        clk;
  logic        rst;
  logic        fetch_enable;
  logic        branch;
  logic [31:0] branch_addr;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_valid;
  logic [31:0] decode_rdata;
  logic [31:0] decode_addr;
  logic        instr_ready;
  logic        accept;

  // Reference state kept by the testbench
  logic [31:0] exp_addr;
  logic [31:0] branch_tgt;
  logic        after_branch;
  logic        stall_d;
  logic [31:0] hold_addr;
  logic [31:0] hold_rdata;
  logic        wait_d;
  logic [31:0] bus_addr_d;
  logic        rst_d = 1'b0;
  int          outstanding;
  int          accepted;

  assign accept = instr_valid && instr_ready;

  fetch_unit i_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .fetch_enable_i (fetch_enable),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .instr_valid_o  (instr_valid),
    .instr_rdata_o  (decode_rdata),
    .decode_addr_o  (decode_addr),
    .instr_ready_i  (instr_ready)
  );

  fetch_mem_model i_mem (
    .clk_i    (clk),
    .rst_i    (rst),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("sim failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "Stopped at first error");
  endtask

  // Random decode stalls and branches, fetch paused for a short window
  task automatic drive_cycle(input int cyc);
    instr_ready  = ($urandom_range(3, 0) != 0);
    fetch_enable = !(cyc >= 150 && cyc < 160);
    if (branch) begin
      branch = 1'b0;
    end else if ($urandom_range(39, 0) == 0) begin
      branch      = 1'b1;
      branch_addr = $urandom & 32'h0000_3FFC;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    rst_d      <= rst;
    stall_d    <= !rst && instr_valid && !instr_ready;
    hold_addr  <= decode_addr;
    hold_rdata <= decode_rdata;
    wait_d     <= !rst && instr_req && !instr_gnt;
    bus_addr_d <= instr_addr;
    if (rst) begin
      exp_addr     <= '0;
      after_branch <= 1'b0;
      outstanding  <= 0;
      accepted     <= 0;
    end else begin
      outstanding <= outstanding + (instr_req && instr_gnt) - instr_rvalid;
      accepted    <= accepted + accept;
      if (branch) begin
        exp_addr     <= branch_addr;
        branch_tgt   <= branch_addr;
        after_branch <= 1'b1;
      end else if (accept) begin
        exp_addr     <= exp_addr + 32'd4;
        after_branch <= 1'b0;
      end
    end
  end

  a_data_rule: assert property (@(posedge clk) disable iff (rst)
    accept |-> decode_rdata == (decode_addr ^ CONTENT_XOR))
    else report_mismatch("instr_rdata_o", $sampled(decode_rdata),
                         $sampled(decode_addr) ^ CONTENT_XOR);

  a_addr_sequence: assert property (@(posedge clk) disable iff (rst)
    accept && !after_branch |-> decode_addr == exp_addr)
    else report_mismatch("decode_addr_o", $sampled(decode_addr), $sampled(exp_addr));

  // First instruction after a redirect comes from the target
  a_branch_target: assert property (@(posedge clk) disable iff (rst)
    accept && after_branch |-> decode_addr == branch_tgt)
    else report_mismatch("decode_addr_o", $sampled(decode_addr), $sampled(branch_tgt));

  a_stall_addr: assert property (@(posedge clk) disable iff (rst)
    stall_d |-> decode_addr == hold_addr)
    else report_mismatch("decode_addr_o", $sampled(decode_addr), $sampled(hold_addr));

  a_stall_rdata: assert property (@(posedge clk) disable iff (rst)
    stall_d |-> decode_rdata == hold_rdata)
    else report_mismatch("instr_rdata_o", $sampled(decode_rdata), $sampled(hold_rdata));

  a_outstanding: assert property (@(posedge clk) disable iff (rst)
    outstanding <= fetch_pkg::FIFO_DEPTH)
    else report_failure("more requests granted and unanswered than the FIFO depth");

  a_reset_quiet: assert property (@(posedge clk)
    rst_d |-> !instr_req && !instr_valid)
    else report_failure("request or valid high during or just after reset");

  a_bus_hold: assert property (@(posedge clk) disable iff (rst)
    wait_d |-> instr_req && instr_addr == bus_addr_d)
    else report_mismatch("instr_addr_o", $sampled(instr_addr), $sampled(bus_addr_d));

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    rst          = 1'b1;
    fetch_enable = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    instr_ready  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    fetch_enable = 1'b1;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(negedge clk);
      drive_cycle(cyc);
    end
    if (accepted < MIN_ACCEPTED) begin
      $display("Error: only %0d instructions reached decode", accepted);
      $display("sim failed");
      $fatal(1, "Too little traffic");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
hdl/fetch_pkg.sv
hdl/fetch_fifo.sv
hdl/fetch_prefetch_controller.sv
hdl/fetch_output_stage.sv
hdl/fetch_unit.sv
verification/fetch_mem_model.sv
verification/fetch_unit_tb.sv
